// ==== verilog/exec_pkg.sv ====
package exec_pkg;

  // datapath widths
  localparam int WORD_W     = 32;
  localparam int REG_W      = 5;
  localparam int CB_ENTRIES = 16;

  // function unit depths
  localparam int MUL_STAGES = 3;
  localparam int DIV_STEPS  = 32;

  typedef logic [WORD_W-1:0]             word_t;
  typedef logic [REG_W-1:0]              reg_idx_t;
  typedef logic [$clog2(CB_ENTRIES)-1:0] cb_idx_t;

  // ops handled by the execute stage
  typedef enum logic [4:0] {
    OP_ADD     = 5'd0,
    OP_SUB     = 5'd1,
    OP_AND     = 5'd2,
    OP_OR      = 5'd3,
    OP_XOR     = 5'd4,
    OP_SLL     = 5'd5,
    OP_SRL     = 5'd6,
    OP_SLT     = 5'd7,
    OP_BEQ     = 5'd8,
    OP_BNE     = 5'd9,
    OP_BLT     = 5'd10,
    OP_BGE     = 5'd11,
    OP_JAL     = 5'd12,
    OP_MUL     = 5'd13,
    OP_DIVU    = 5'd14,
    OP_REMU    = 5'd15,
    OP_ILLEGAL = 5'd31
  } exec_op_e;

  typedef enum logic [1:0] {
    NO_EXCEPTION = 2'd0,
    ILLEGAL      = 2'd1,
    MAL_NORMAL   = 2'd2
  } exc_e;

  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_RUN  = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

  // instruction as it leaves the issue queue
  typedef struct packed {
    logic     valid;
    exec_op_e op;
    word_t    rs1;
    word_t    rs2;
    word_t    imm;
    word_t    pc;
    logic     prediction;
    reg_idx_t vd;
    cb_idx_t  index;
  } issue_t;

  // finished result of one function unit
  typedef struct packed {
    logic     ready;
    logic     wen;
    cb_idx_t  index;
    reg_idx_t vd;
    word_t    wdata;
    exc_e     exc;
  } fu_result_t;

  // completion buffer writeback carries the same fields
  typedef fu_result_t cb_wb_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

endpackage

// ==== verilog/alu_branch_unit.sv ====
`timescale 1ns/100ps

module alu_branch_unit (
  input  logic                 CLK,
  input  logic                 nRST,
  input  exec_pkg::issue_t     issue,
  output exec_pkg::fu_result_t alu_res,
  output exec_pkg::redirect_t  redirect
);

  logic                 owned;
  logic                 is_branch;
  logic                 is_jal;
  logic                 illegal;
  logic                 taken;
  logic                 misaligned;
  exec_pkg::word_t      result;
  exec_pkg::word_t      target;
  exec_pkg::word_t      pc4;
  exec_pkg::fu_result_t res_d;
  exec_pkg::fu_result_t res_q;
  logic                 redir_valid_d;
  logic                 redir_valid_q;
  exec_pkg::word_t      redir_target_q;

  // everything except mul and div belongs to this unit
  assign owned = issue.valid &&
                 !(issue.op inside {exec_pkg::OP_MUL, exec_pkg::OP_DIVU, exec_pkg::OP_REMU});
  assign target = issue.pc + issue.imm;
  assign pc4    = issue.pc + 32'd4;

  always_comb begin
    result    = '0;
    taken     = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    illegal   = 1'b0;
    case (issue.op)
      exec_pkg::OP_ADD: result = issue.rs1 + issue.rs2;
      exec_pkg::OP_SUB: result = issue.rs1 - issue.rs2;
      exec_pkg::OP_AND: result = issue.rs1 & issue.rs2;
      exec_pkg::OP_OR:  result = issue.rs1 | issue.rs2;
      exec_pkg::OP_XOR: result = issue.rs1 ^ issue.rs2;
      exec_pkg::OP_SLL: result = issue.rs1 << issue.rs2[4:0];
      exec_pkg::OP_SRL: result = issue.rs1 >> issue.rs2[4:0];
      exec_pkg::OP_SLT: result = {31'b0, $signed(issue.rs1) < $signed(issue.rs2)};
      exec_pkg::OP_BEQ: begin
        is_branch = 1'b1;
        taken     = (issue.rs1 == issue.rs2);
      end
      exec_pkg::OP_BNE: begin
        is_branch = 1'b1;
        taken     = (issue.rs1 != issue.rs2);
      end
      exec_pkg::OP_BLT: begin
        is_branch = 1'b1;
        taken     = ($signed(issue.rs1) < $signed(issue.rs2));
      end
      exec_pkg::OP_BGE: begin
        is_branch = 1'b1;
        taken     = ($signed(issue.rs1) >= $signed(issue.rs2));
      end
      exec_pkg::OP_JAL: begin
        is_jal = 1'b1;
        taken  = 1'b1;
      end
      // owned already masks the mul and div ops that land here
      default: illegal = 1'b1;
    endcase
  end

  assign misaligned = (is_branch || is_jal) && taken && (target[1:0] != 2'b00);

  always_comb begin
    res_d.ready = owned;
    res_d.index = issue.index;
    res_d.vd    = issue.vd;
    if (illegal) begin
      res_d.exc   = exec_pkg::ILLEGAL;
      res_d.wdata = issue.pc;
      res_d.wen   = 1'b0;
    end else if (misaligned) begin
      res_d.exc   = exec_pkg::MAL_NORMAL;
      res_d.wdata = issue.pc;
      res_d.wen   = 1'b0;
    end else begin
      res_d.exc   = exec_pkg::NO_EXCEPTION;
      res_d.wdata = is_jal ? pc4 : result;
      res_d.wen   = !is_branch;
    end
  end

  // redirect only when resolution disagrees with the prediction
  assign redir_valid_d = owned && (is_branch || is_jal) && !misaligned &&
                         (taken ^ issue.prediction);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      res_q         <= '0;
      redir_valid_q <= 1'b0;
    end else begin
      res_q         <= res_d;
      redir_valid_q <= redir_valid_d;
    end
  end

  always_ff @(posedge CLK) begin
    redir_target_q <= taken ? target : pc4;
  end

  assign alu_res = res_q;

  assign redirect.valid  = redir_valid_q;
  assign redirect.target = redir_target_q;

endmodule

// ==== verilog/multiply_pipe.sv ====
`timescale 1ns/100ps

module multiply_pipe (
  input  logic                 CLK,
  input  logic                 nRST,
  input  exec_pkg::issue_t     issue,
  output exec_pkg::fu_result_t mul_res,
  output logic                 mul_completing_next
);

  logic                              take;
  logic [exec_pkg::MUL_STAGES-1:0]   vld_q;
  exec_pkg::reg_idx_t                vd_q  [exec_pkg::MUL_STAGES];
  exec_pkg::cb_idx_t                 idx_q [exec_pkg::MUL_STAGES];
  exec_pkg::word_t                   a_q;
  exec_pkg::word_t                   b_q;
  exec_pkg::word_t                   p_low_q;
  logic [15:0]                       p_cross_q;
  exec_pkg::word_t                   product_q;

  assign take = issue.valid && (issue.op == exec_pkg::OP_MUL);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[exec_pkg::MUL_STAGES-2:0], take};
    end
  end

  always_ff @(posedge CLK) begin
    // tags follow the data down the pipe
    vd_q[0]  <= issue.vd;
    idx_q[0] <= issue.index;
    for (int s = 1; s < exec_pkg::MUL_STAGES; s++) begin
      vd_q[s]  <= vd_q[s-1];
      idx_q[s] <= idx_q[s-1];
    end
    // stage 1 operands
    a_q <= issue.rs1;
    b_q <= issue.rs2;
    // stage 2 partial products, cross terms only matter in their low half
    p_low_q   <= a_q[15:0] * b_q[15:0];
    p_cross_q <= a_q[31:16] * b_q[15:0] + a_q[15:0] * b_q[31:16];
    // stage 3 final sum
    product_q <= p_low_q + {p_cross_q, 16'h0000};
  end

  assign mul_completing_next = vld_q[exec_pkg::MUL_STAGES-2];

  assign mul_res.ready = vld_q[exec_pkg::MUL_STAGES-1];
  assign mul_res.wen   = vld_q[exec_pkg::MUL_STAGES-1];
  assign mul_res.index = idx_q[exec_pkg::MUL_STAGES-1];
  assign mul_res.vd    = vd_q[exec_pkg::MUL_STAGES-1];
  assign mul_res.wdata = product_q;
  assign mul_res.exc   = exec_pkg::NO_EXCEPTION;

endmodule

// ==== verilog/divide_iter.sv ====
`timescale 1ns/100ps

module divide_iter (
  input  logic                 CLK,
  input  logic                 nRST,
  input  exec_pkg::issue_t     issue,
  input  logic                 div_start,
  input  logic                 div_grant,
  output exec_pkg::fu_result_t div_res
);

  logic                                   running_q;
  logic                                   done_q;
  logic [$clog2(exec_pkg::DIV_STEPS)-1:0] count_q;
  logic                                   last_step;
  exec_pkg::word_t                        quo_q;
  exec_pkg::word_t                        rem_q;
  exec_pkg::word_t                        divisor_q;
  exec_pkg::reg_idx_t                     vd_q;
  exec_pkg::cb_idx_t                      idx_q;
  logic                                   is_rem_q;
  logic [exec_pkg::WORD_W:0]              shifted;
  logic [exec_pkg::WORD_W:0]              trial;
  logic                                   fits;

  // restoring step: bring in the next dividend bit, subtract if it fits
  assign shifted = {rem_q, quo_q[exec_pkg::WORD_W-1]};
  assign trial   = shifted - {1'b0, divisor_q};
  assign fits    = !trial[exec_pkg::WORD_W];

  assign last_step = (int'(count_q) == exec_pkg::DIV_STEPS - 1);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
      count_q   <= '0;
    end else begin
      if (div_start) begin
        running_q <= 1'b1;
        count_q   <= '0;
      end else if (running_q) begin
        count_q <= count_q + 1'b1;
        if (last_step) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
      // result stays up until the port takes it
      if (div_grant) begin
        done_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (div_start) begin
      quo_q     <= issue.rs1;
      rem_q     <= '0;
      divisor_q <= issue.rs2;
      vd_q      <= issue.vd;
      idx_q     <= issue.index;
      is_rem_q  <= (issue.op == exec_pkg::OP_REMU);
    end else if (running_q) begin
      // zero divisor always fits, giving all ones and rem = dividend
      quo_q <= {quo_q[exec_pkg::WORD_W-2:0], fits};
      rem_q <= fits ? trial[exec_pkg::WORD_W-1:0] : shifted[exec_pkg::WORD_W-1:0];
    end
  end

  assign div_res.ready = done_q;
  assign div_res.wen   = done_q;
  assign div_res.index = idx_q;
  assign div_res.vd    = vd_q;
  assign div_res.wdata = is_rem_q ? rem_q : quo_q;
  assign div_res.exc   = exec_pkg::NO_EXCEPTION;

endmodule

// ==== verilog/exec_control.sv ====
`timescale 1ns/100ps

module exec_control (
  input  logic                 CLK,
  input  logic                 nRST,
  input  exec_pkg::issue_t     issue,
  input  exec_pkg::fu_result_t alu_res,
  input  exec_pkg::fu_result_t mul_res,
  input  exec_pkg::fu_result_t div_res,
  input  logic                 mul_completing_next,
  output logic                 div_start,
  output logic                 div_grant,
  output exec_pkg::cb_wb_t     wb,
  output logic                 busy_alu,
  output logic                 busy_div
);

  exec_pkg::div_state_e state_q;
  exec_pkg::div_state_e state_d;
  logic                 div_issue;

  assign div_issue = issue.valid &&
                     (issue.op inside {exec_pkg::OP_DIVU, exec_pkg::OP_REMU});

  // the divider accepts only from idle
  assign div_start = div_issue && (state_q == exec_pkg::DIV_IDLE);

  // divider gets the port only when the fixed-latency units are quiet
  assign div_grant = (state_q != exec_pkg::DIV_IDLE) && div_res.ready &&
                     !mul_res.ready && !alu_res.ready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      exec_pkg::DIV_IDLE: begin
        if (div_start) begin
          state_d = exec_pkg::DIV_RUN;
        end
      end
      exec_pkg::DIV_RUN: begin
        // result may be taken the very cycle it appears
        if (div_grant) begin
          state_d = exec_pkg::DIV_IDLE;
        end else if (div_res.ready) begin
          state_d = exec_pkg::DIV_DONE;
        end
      end
      exec_pkg::DIV_DONE: begin
        if (div_grant) begin
          state_d = exec_pkg::DIV_IDLE;
        end
      end
      default: begin
        state_d = exec_pkg::DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state_q <= exec_pkg::DIV_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // writeback priority: mul, then alu/branch, then div
  always_comb begin
    if (mul_res.ready) begin
      wb = mul_res;
    end else if (alu_res.ready) begin
      wb = alu_res;
    end else if (div_grant) begin
      wb = div_res;
    end else begin
      wb = '0;
    end
  end

  // a multiply in stage 2 owns the port next cycle
  assign busy_alu = mul_completing_next;
  assign busy_div = (state_q != exec_pkg::DIV_IDLE);

endmodule

// ==== verilog/exec_stage.sv ====
`timescale 1ns/100ps

module exec_stage (
  input  logic                CLK,
  input  logic                nRST,
  input  exec_pkg::issue_t    issue,
  output exec_pkg::cb_wb_t    wb,
  output exec_pkg::redirect_t redirect,
  output logic                busy_alu,
  output logic                busy_div
);

  exec_pkg::fu_result_t alu_res;
  exec_pkg::fu_result_t mul_res;
  exec_pkg::fu_result_t div_res;
  logic                 mul_completing_next;
  logic                 div_start;
  logic                 div_grant;

  // single cycle arithmetic, branches and jumps
  alu_branch_unit u_alu (
    .CLK      (CLK),
    .nRST     (nRST),
    .issue    (issue),
    .alu_res  (alu_res),
    .redirect (redirect)
  );

  multiply_pipe u_mul (
    .CLK                 (CLK),
    .nRST                (nRST),
    .issue               (issue),
    .mul_res             (mul_res),
    .mul_completing_next (mul_completing_next)
  );

  // divider holds its result until granted
  divide_iter u_div (
    .CLK       (CLK),
    .nRST      (nRST),
    .issue     (issue),
    .div_start (div_start),
    .div_grant (div_grant),
    .div_res   (div_res)
  );

  exec_control u_ctrl (
    .CLK                 (CLK),
    .nRST                (nRST),
    .issue               (issue),
    .alu_res             (alu_res),
    .mul_res             (mul_res),
    .div_res             (div_res),
    .mul_completing_next (mul_completing_next),
    .div_start           (div_start),
    .div_grant           (div_grant),
    .wb                  (wb),
    .busy_alu            (busy_alu),
    .busy_div            (busy_div)
  );

endmodule

// ==== testbench/exec_stage_assertions.sv ====
`timescale 1ns/100ps

module exec_stage_assertions (
  input logic                CLK,
  input logic                nRST,
  input exec_pkg::issue_t    issue,
  input exec_pkg::cb_wb_t    wb,
  input exec_pkg::redirect_t redirect,
  input logic                busy_alu,
  input logic                busy_div
);

  int   fails = 0;
  logic div_op;
  logic alu_op;

  assign div_op = issue.op inside {exec_pkg::OP_DIVU, exec_pkg::OP_REMU};
  assign alu_op = !div_op && (issue.op != exec_pkg::OP_MUL);

  // fixed-latency units share the port with the multiplier
  a_busy_alu: assert property (@(posedge CLK) disable iff (!nRST)
    issue.valid && !div_op |-> !busy_alu)
    else begin
      $error("non-divide op issued while busy_alu is high");
      fails++;
    end

  a_busy_div: assert property (@(posedge CLK) disable iff (!nRST)
    issue.valid && div_op |-> !busy_div)
    else begin
      $error("divide issued while busy_div is high");
      fails++;
    end

  a_wen_exc: assert property (@(posedge CLK) disable iff (!nRST)
    wb.wen |-> wb.exc == exec_pkg::NO_EXCEPTION)
    else begin
      $error("wb.wen set on an excepting result");
      fails++;
    end

  // redirect comes only from the alu/branch unit, one cycle on
  a_redirect: assert property (@(posedge CLK) disable iff (!nRST)
    redirect.valid |-> $past(issue.valid && alu_op))
    else begin
      $error("redirect.valid without an alu-class issue the cycle before");
      fails++;
    end

endmodule

bind exec_stage exec_stage_assertions u_assert (.*);

// ==== testbench/exec_stage_tb.sv ====
`timescale 1ns/100ps

module exec_stage_tb;

  localparam int TOTAL = 40 + 60 + 40 + 12 + 200;
  localparam int LIMIT = TOTAL * 40 + 200;

  logic                CLK;
  logic                nRST;
  exec_pkg::issue_t    issue;
  exec_pkg::cb_wb_t    wb;
  exec_pkg::redirect_t redirect;
  logic                busy_alu;
  logic                busy_div;

  // scoreboard slot per completion-buffer index
  exec_pkg::cb_wb_t    exp_q [16];
  bit                  pend_q [16];
  int                  kind_q [16];
  int                  edge_q [16];
  bit                  mul_edge [0:LIMIT+15];
  exec_pkg::redirect_t rd_pipe0;
  exec_pkg::redirect_t rd_pipe1;
  exec_pkg::cb_idx_t   next_idx;
  bit                  div_active;
  int                  div_edge;
  int                  outstanding;
  int                  cyc;
  int                  checks;
  int                  errors;
  int                  wd_count = 0;

  exec_stage UUT (
    .CLK      (CLK),
    .nRST     (nRST),
    .issue    (issue),
    .wb       (wb),
    .redirect (redirect),
    .busy_alu (busy_alu),
    .busy_div (busy_div)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    wd_count <= wd_count + 1;
    if (wd_count >= LIMIT) begin
      $display("timeout after %0d cycles, %0d results never arrived", wd_count, outstanding);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic report_fault(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_wb(input string name, input exec_pkg::cb_wb_t exp,
                          input exec_pkg::cb_wb_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_redirect(input string name, input exec_pkg::redirect_t exp,
                                input exec_pkg::redirect_t act);
    checks++;
    if (act.valid !== exp.valid || (exp.valid && act.target !== exp.target)) begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_busy(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  // reference model built from the RISC-V rules
  task automatic model_result(input exec_pkg::issue_t it, output exec_pkg::cb_wb_t w,
                              output exec_pkg::redirect_t rd);
    logic            ctl;
    logic            taken;
    logic [63:0]     prod;
    exec_pkg::word_t tgt;
    w = '0;
    rd = '0;
    ctl = 1'b0;
    taken = 1'b0;
    w.ready = 1'b1;
    w.wen = 1'b1;
    w.index = it.index;
    w.vd = it.vd;
    w.exc = exec_pkg::NO_EXCEPTION;
    tgt = it.pc + it.imm;
    prod = 64'(it.rs1) * 64'(it.rs2);
    case (it.op)
      exec_pkg::OP_ADD: w.wdata = it.rs1 + it.rs2;
      exec_pkg::OP_SUB: w.wdata = it.rs1 - it.rs2;
      exec_pkg::OP_AND: w.wdata = it.rs1 & it.rs2;
      exec_pkg::OP_OR:  w.wdata = it.rs1 | it.rs2;
      exec_pkg::OP_XOR: w.wdata = it.rs1 ^ it.rs2;
      exec_pkg::OP_SLL: w.wdata = it.rs1 << it.rs2[4:0];
      exec_pkg::OP_SRL: w.wdata = it.rs1 >> it.rs2[4:0];
      exec_pkg::OP_SLT: w.wdata = (int'(it.rs1) < int'(it.rs2)) ? 32'd1 : 32'd0;
      exec_pkg::OP_BEQ: {ctl, taken} = {1'b1, it.rs1 == it.rs2};
      exec_pkg::OP_BNE: {ctl, taken} = {1'b1, it.rs1 != it.rs2};
      exec_pkg::OP_BLT: {ctl, taken} = {1'b1, int'(it.rs1) < int'(it.rs2)};
      exec_pkg::OP_BGE: {ctl, taken} = {1'b1, int'(it.rs1) >= int'(it.rs2)};
      exec_pkg::OP_JAL: {ctl, taken, w.wdata} = {2'b11, it.pc + 32'd4};
      exec_pkg::OP_MUL: w.wdata = prod[31:0];
      exec_pkg::OP_DIVU: w.wdata = (it.rs2 == 0) ? 32'hffff_ffff : it.rs1 / it.rs2;
      exec_pkg::OP_REMU: w.wdata = (it.rs2 == 0) ? it.rs1 : it.rs1 % it.rs2;
      default: begin
        w.exc = exec_pkg::ILLEGAL;
        w.wdata = it.pc;
        w.wen = 1'b0;
      end
    endcase
    // branches strobe wb but write no register
    if (ctl && it.op != exec_pkg::OP_JAL) begin
      w.wen = 1'b0;
    end
    if (ctl && taken && tgt[1:0] != 2'b00) begin
      w.exc = exec_pkg::MAL_NORMAL;
      w.wdata = it.pc;
      w.wen = 1'b0;
    end else if (ctl) begin
      rd.valid = taken ^ it.prediction;
      rd.target = taken ? tgt : it.pc + 32'd4;
    end
  endtask

  // compare everything the DUT shows before this edge
  task automatic observe();
    exec_pkg::cb_wb_t act;
    int               i;
    act = wb;
    check_redirect("redirect", rd_pipe1, redirect);
    rd_pipe1 = rd_pipe0;
    rd_pipe0 = '0;
    check_busy("busy_alu", mul_edge[cyc-2], busy_alu);
    check_busy("busy_div", div_active && div_edge < cyc, busy_div);
    if (act.ready && !pend_q[act.index]) begin
      report_fault($sformatf("wb strobe for index %0d with nothing outstanding", act.index));
    end else if (act.ready) begin
      check_wb("wb", exp_q[act.index], act);
      pend_q[act.index] = 1'b0;
      outstanding--;
      if (kind_q[act.index] == 2) begin
        div_active = 1'b0;
        if (cyc < edge_q[act.index] + 33) begin
          report_fault($sformatf("divide at index %0d finished too early", act.index));
        end
      end else if (cyc != edge_q[act.index] + ((kind_q[act.index] == 1) ? 3 : 1)) begin
        report_fault($sformatf("index %0d completed at the wrong cycle", act.index));
      end
    end
    for (i = 0; i < 16; i++) begin
      if (pend_q[i] && kind_q[i] != 2 && cyc > edge_q[i] + ((kind_q[i] == 1) ? 3 : 1)) begin
        report_fault($sformatf("no result arrived for index %0d", i));
        pend_q[i] = 1'b0;
        outstanding--;
      end
    end
  endtask

  // mode 0 arith, 1 branch/jal/illegal, 2 mul, 3 div, 4 mixed, -1 idle
  task automatic issue_next(input int mode, output bit done);
    exec_pkg::issue_t    it;
    exec_pkg::cb_wb_t    w;
    exec_pkg::redirect_t rd;
    int                  r;
    int                  cls;
    bit                  ok;
    it = '0;
    done = 1'b0;
    r = $urandom % 100;
    cls = (mode < 4) ? mode : (r < 30) ? 0 : (r < 55) ? 1 : (r < 85) ? 2 : 3;
    ok = (mode >= 0) && ($urandom % 8 != 0) && !pend_q[next_idx] &&
         ((cls == 3) ? !div_active : !mul_edge[cyc-1]);
    if (pend_q[next_idx]) begin
      next_idx = next_idx + 1'b1;
    end
    if (ok) begin
      r = $urandom % 12;
      case (cls)
        0: it.op = exec_pkg::exec_op_e'(5'($urandom % 8));
        1: it.op = (r < 10) ? exec_pkg::exec_op_e'(5'(8 + r % 5)) : exec_pkg::OP_ILLEGAL;
        2: it.op = exec_pkg::OP_MUL;
        default: it.op = (r < 6) ? exec_pkg::OP_DIVU : exec_pkg::OP_REMU;
      endcase
      it.valid = 1'b1;
      it.rs1 = $urandom;
      it.rs2 = $urandom >> ($urandom % 32);
      // occasional equal operands or zero divisor
      if ($urandom % 5 == 0) begin
        it.rs2 = (cls == 3) ? '0 : it.rs1;
      end
      it.pc = $urandom & 32'hffff_fffc;
      it.imm = ($urandom & 32'h0000_0ffc) - 32'd2048;
      if ($urandom % 5 == 0) begin
        it.imm[1:0] = 2'($urandom);
      end
      it.prediction = 1'($urandom);
      it.vd = 5'($urandom);
      it.index = next_idx;
      model_result(it, w, rd);
      exp_q[next_idx] = w;
      pend_q[next_idx] = 1'b1;
      kind_q[next_idx] = (cls == 2) ? 1 : (cls == 3) ? 2 : 0;
      edge_q[next_idx] = cyc + 1;
      mul_edge[cyc+1] = (cls == 2);
      if (cls == 3) begin
        div_active = 1'b1;
        div_edge = cyc + 1;
      end
      rd_pipe0 = rd;
      next_idx = next_idx + 1'b1;
      outstanding++;
      done = 1'b1;
    end
    issue <= it;
  endtask

  task automatic run_test(input string name, input int mode, input int count);
    int issued;
    int err0;
    bit done;
    issued = 0;
    err0 = errors;
    while (issued < count || outstanding > 0) begin
      @(posedge CLK);
      cyc++;
      observe();
      issue_next((issued < count) ? mode : -1, done);
      issued += done;
    end
    $display("test %s: %0d issued, %0d errors", name, issued, errors - err0);
  endtask

  initial begin
    int fails;
    void'($urandom(32'h904f));
    nRST = 1'b0;
    issue = '0;
    rd_pipe0 = '0;
    rd_pipe1 = '0;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
    cyc = 6;
    check_busy("wb.ready", 1'b0, wb.ready);
    check_busy("redirect.valid", 1'b0, redirect.valid);
    check_busy("busy_alu", 1'b0, busy_alu);
    check_busy("busy_div", 1'b0, busy_div);
    $display("test reset: %0d errors", errors);
    run_test("alu", 0, 40);
    run_test("branch", 1, 60);
    run_test("mul", 2, 40);
    run_test("div", 3, 12);
    run_test("mixed", 4, 200);
    fails = UUT.u_assert.fails;
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors, fails);
    if (errors + fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
verilog/exec_pkg.sv
verilog/alu_branch_unit.sv
verilog/multiply_pipe.sv
verilog/divide_iter.sv
verilog/exec_control.sv
verilog/exec_stage.sv
testbench/exec_stage_assertions.sv
testbench/exec_stage_tb.sv
